//--- source/systolic_pkg.sv
//////////////////////////////
// Systolic kernel package
// Array sizes, stream lengths, lane types and kernel phases
//////////////////////////////
package systolic_pkg;

  // Array geometry
  localparam int ARRAY_DIM = 4;
  localparam int WORD_W    = 32;
  localparam int BEAT_W    = ARRAY_DIM * WORD_W;

  // Input and output beats per run, skewed over the array diagonal
  localparam int STREAM_BEATS = 2 * ARRAY_DIM - 1;

  // Zero steps that push the last rows out to the output register
  localparam int DRAIN_STEPS = ARRAY_DIM;
  localparam int TOTAL_STEPS = STREAM_BEATS + DRAIN_STEPS;

  // Counter widths
  localparam int STEP_CNT_W = $clog2(TOTAL_STEPS + 1);
  localparam int OUT_CNT_W  = $clog2(STREAM_BEATS);
  localparam int WCNT_W     = $clog2(ARRAY_DIM);

  // One lane word, and a full beat with lane 0 in the top word
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BEAT_W-1:0] beat_t;

  typedef enum logic [1:0] {
    phase_idle,
    phase_load,
    phase_stream,
    phase_finish
  } phase_e;

endpackage

//--- source/mac_cell.sv
//////////////////////////////
// MAC cell
// Holds one weight, passes activation right and partial sum down
//////////////////////////////
`timescale 1ns/100ps

module mac_cell (
  input  logic                ap_clk,
  input  logic                areset,
  input  logic                weight_shift,
  input  systolic_pkg::word_t weight_in,
  input  logic                step,
  input  systolic_pkg::word_t act_in,
  input  systolic_pkg::word_t psum_in,
  output systolic_pkg::word_t weight_out,
  output systolic_pkg::word_t act_out,
  output systolic_pkg::word_t psum_out
);
  import systolic_pkg::*;

  word_t weight_q;

  // Column shift register for the stationary weight
  always_ff @(posedge ap_clk) begin
    if (weight_shift) begin
      weight_q <= weight_in;
    end
  end

  assign weight_out = weight_q;

  // One array position per step, product wraps to 32 bits
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      act_out  <= '0;
      psum_out <= '0;
    end else if (step) begin
      act_out  <= act_in;
      psum_out <= psum_in + act_in * weight_q;
    end
  end

endmodule

//--- source/systolic_array.sv
//////////////////////////////
// Systolic array
// Weight-stationary grid of MAC cells with lane unpack and pack
//////////////////////////////
`timescale 1ns/100ps

module systolic_array (
  input  logic                ap_clk,
  input  logic                areset,
  input  logic                weight_shift,
  input  systolic_pkg::beat_t weight_beat,
  input  logic                step,
  input  systolic_pkg::beat_t act_beat,
  output systolic_pkg::beat_t psum_beat
);
  import systolic_pkg::*;

  // Horizontal activation links, one extra column on the right edge
  word_t act_h  [ARRAY_DIM][ARRAY_DIM+1];
  // Vertical partial sum and weight links, one extra row at the bottom
  word_t psum_v [ARRAY_DIM+1][ARRAY_DIM];
  word_t wgt_v  [ARRAY_DIM+1][ARRAY_DIM];

  genvar r, c;

  // Row r takes lane r, lane 0 sits in the top word
  for (r = 0; r < ARRAY_DIM; r++) begin : g_row_in
    assign act_h[r][0] = act_beat[(ARRAY_DIM-1-r)*WORD_W +: WORD_W];
  end

  //////////////////////////////
  // Column edges
  //////////////////////////////
  for (c = 0; c < ARRAY_DIM; c++) begin : g_col_edge
    assign wgt_v[0][c]  = weight_beat[(ARRAY_DIM-1-c)*WORD_W +: WORD_W];
    assign psum_v[0][c] = '0;
    assign psum_beat[(ARRAY_DIM-1-c)*WORD_W +: WORD_W] = psum_v[ARRAY_DIM][c];
  end

  for (r = 0; r < ARRAY_DIM; r++) begin : g_row
    for (c = 0; c < ARRAY_DIM; c++) begin : g_col
      mac_cell cell_i (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .weight_shift (weight_shift),
        .weight_in    (wgt_v[r][c]),
        .step         (step),
        .act_in       (act_h[r][c]),
        .psum_in      (psum_v[r][c]),
        .weight_out   (wgt_v[r+1][c]),
        .act_out      (act_h[r][c+1]),
        .psum_out     (psum_v[r+1][c])
      );
    end
  end

endmodule

//--- source/kernel_control.sv
//////////////////////////////
// Kernel control
// Start detection, phase sequencing and idle/done/ready status
//////////////////////////////
`timescale 1ns/100ps

module kernel_control (
  input  logic                 ap_clk,
  input  logic                 areset,
  input  logic                 ap_start,
  input  logic                 weights_loaded,
  input  logic                 stream_done,
  output logic                 start_pulse,
  output systolic_pkg::phase_e phase,
  output logic                 ap_idle,
  output logic                 ap_done,
  output logic                 ap_ready
);
  import systolic_pkg::*;

  logic ap_start_r;

  // Rising edge of ap_start taken only while idle
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_r  <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      ap_start_r  <= ap_start;
      start_pulse <= ap_start && !ap_start_r && (phase == phase_idle);
    end
  end

  //////////////////////////////
  // Phase sequencing
  //////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      phase <= phase_idle;
    end else begin
      case (phase)
        phase_idle:   if (start_pulse) phase <= phase_load;
        phase_load:   if (weights_loaded) phase <= phase_stream;
        phase_stream: if (stream_done) phase <= phase_finish;
        default:      phase <= phase_idle;
      endcase
    end
  end

  // Idle returns with done and drops the cycle after start
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_idle <= 1'b1;
    end else if ((phase == phase_stream) && stream_done) begin
      ap_idle <= 1'b1;
    end else if (start_pulse) begin
      ap_idle <= 1'b0;
    end
  end

  // Finish lasts a single cycle
  assign ap_done  = (phase == phase_finish);
  assign ap_ready = ap_done;

  a_done_single: assert property (
    @(posedge ap_clk) disable iff (areset)
      ap_done |-> ap_idle ##1 (!ap_done && ap_idle)
  ) else $error("ap_done not a single-cycle pulse with idle set");

endmodule

//--- source/weight_loader.sv
//////////////////////////////
// Weight loader
// Takes four weight beats and shifts them down the array columns
//////////////////////////////
`timescale 1ns/100ps

module weight_loader (
  input  logic                 ap_clk,
  input  logic                 areset,
  input  logic                 start_pulse,
  input  systolic_pkg::phase_e phase,
  input  logic                 weight_tvalid,
  input  systolic_pkg::beat_t  weight_tdata,
  output logic                 weight_tready,
  output logic                 weight_shift,
  output systolic_pkg::beat_t  weight_beat,
  output logic                 weights_loaded
);
  import systolic_pkg::*;

  logic [WCNT_W-1:0] beat_cnt;

  // Ready until the last row is in
  assign weight_tready = (phase == phase_load) && !weights_loaded;
  assign weight_shift  = weight_tvalid && weight_tready;

  // Top row of the array takes the beat as it is accepted
  assign weight_beat = weight_tdata;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      beat_cnt       <= '0;
      weights_loaded <= 1'b0;
    end else if (start_pulse) begin
      beat_cnt       <= '0;
      weights_loaded <= 1'b0;
    end else if (weight_shift) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (beat_cnt == WCNT_W'(ARRAY_DIM - 1)) begin
        weights_loaded <= 1'b1;
      end
    end
  end

  a_no_extra_beat: assert property (
    @(posedge ap_clk) disable iff (areset)
      (weights_loaded && !start_pulse) |=> !weight_shift
  ) else $error("weight beat accepted after the array was full");

endmodule

//--- source/stream_sequencer.sv
//////////////////////////////
// Stream sequencer
// Feeds input beats and drain zeros, collects output beats
//////////////////////////////
`timescale 1ns/100ps

module stream_sequencer (
  input  logic                 ap_clk,
  input  logic                 areset,
  input  logic                 start_pulse,
  input  systolic_pkg::phase_e phase,
  input  logic                 weights_loaded,
  input  logic                 input_tvalid,
  input  systolic_pkg::beat_t  input_tdata,
  input  systolic_pkg::beat_t  psum_beat,
  input  logic                 output_tready,
  output logic                 input_tready,
  output logic                 step,
  output systolic_pkg::beat_t  act_beat,
  output logic                 output_tvalid,
  output systolic_pkg::beat_t  output_tdata,
  output logic                 output_tlast,
  output logic                 stream_done
);
  import systolic_pkg::*;

  logic [STEP_CNT_W-1:0] step_cnt;
  logic [OUT_CNT_W-1:0]  out_cnt;
  logic                  active;
  logic                  out_free;
  logic                  feeding;
  logic                  draining;
  logic                  capture;
  logic                  out_xfer;

  assign active   = (phase == phase_stream) && weights_loaded;
  // Whole array stalls while a result waits on the output
  assign out_free = !output_tvalid || output_tready;
  assign feeding  = step_cnt < STEP_CNT_W'(STREAM_BEATS);
  assign draining = !feeding && (step_cnt < STEP_CNT_W'(TOTAL_STEPS));

  assign input_tready = active && feeding && out_free;
  assign step         = (input_tvalid && input_tready) || (active && draining && out_free);
  assign act_beat     = feeding ? input_tdata : '0;

  // Bottom row carries valid sums from step DRAIN_STEPS on
  assign capture      = step && (step_cnt >= STEP_CNT_W'(DRAIN_STEPS));
  assign out_xfer     = output_tvalid && output_tready;
  assign output_tlast = output_tvalid && (out_cnt == OUT_CNT_W'(STREAM_BEATS - 1));

  //////////////////////////////
  // Counters and output valid
  //////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      step_cnt      <= '0;
      out_cnt       <= '0;
      output_tvalid <= 1'b0;
      stream_done   <= 1'b0;
    end else begin
      stream_done <= out_xfer && output_tlast;
      if (start_pulse) begin
        step_cnt <= '0;
        out_cnt  <= '0;
      end else begin
        if (step) step_cnt <= step_cnt + 1'b1;
        if (out_xfer) out_cnt <= out_cnt + 1'b1;
      end
      if (capture) begin
        output_tvalid <= 1'b1;
      end else if (output_tready) begin
        output_tvalid <= 1'b0;
      end
    end
  end

  // Output beat register
  always_ff @(posedge ap_clk) begin
    if (capture) begin
      output_tdata <= psum_beat;
    end
  end

  a_out_hold: assert property (
    @(posedge ap_clk) disable iff (areset)
      (output_tvalid && !output_tready) |=> (output_tvalid && $stable(output_tdata))
  ) else $error("output beat changed while stalled");

endmodule

//--- source/systolic_kernel.sv
//////////////////////////////
// Systolic kernel top
// 4x4 weight-stationary matrix multiply on three streams
//////////////////////////////
`timescale 1ns/100ps

module systolic_kernel (
  input  logic                ap_clk,
  input  logic                areset,
  input  logic                ap_start,
  output logic                ap_idle,
  output logic                ap_done,
  output logic                ap_ready,
  output logic                weights_loaded,
  // Weight stream
  input  logic                weight_tvalid,
  output logic                weight_tready,
  input  systolic_pkg::beat_t weight_tdata,
  // Input stream
  input  logic                input_tvalid,
  output logic                input_tready,
  input  systolic_pkg::beat_t input_tdata,
  // Output stream
  output logic                output_tvalid,
  input  logic                output_tready,
  output systolic_pkg::beat_t output_tdata,
  output logic                output_tlast
);
  import systolic_pkg::*;

  logic   start_pulse;
  phase_e phase;
  logic   weight_shift;
  beat_t  weight_beat;
  logic   step;
  beat_t  act_beat;
  beat_t  psum_beat;
  logic   stream_done;

  kernel_control kernel_control_i (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .ap_start       (ap_start),
    .weights_loaded (weights_loaded),
    .stream_done    (stream_done),
    .start_pulse    (start_pulse),
    .phase          (phase),
    .ap_idle        (ap_idle),
    .ap_done        (ap_done),
    .ap_ready       (ap_ready)
  );

  weight_loader weight_loader_i (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .start_pulse    (start_pulse),
    .phase          (phase),
    .weight_tvalid  (weight_tvalid),
    .weight_tdata   (weight_tdata),
    .weight_tready  (weight_tready),
    .weight_shift   (weight_shift),
    .weight_beat    (weight_beat),
    .weights_loaded (weights_loaded)
  );

  systolic_array systolic_array_i (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .weight_shift (weight_shift),
    .weight_beat  (weight_beat),
    .step         (step),
    .act_beat     (act_beat),
    .psum_beat    (psum_beat)
  );

  stream_sequencer stream_sequencer_i (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .start_pulse    (start_pulse),
    .phase          (phase),
    .weights_loaded (weights_loaded),
    .input_tvalid   (input_tvalid),
    .input_tdata    (input_tdata),
    .psum_beat      (psum_beat),
    .output_tready  (output_tready),
    .input_tready   (input_tready),
    .step           (step),
    .act_beat       (act_beat),
    .output_tvalid  (output_tvalid),
    .output_tdata   (output_tdata),
    .output_tlast   (output_tlast),
    .stream_done    (stream_done)
  );

endmodule

//--- verification/systolic_kernel_tb.sv
//////////////////////////////
// Systolic kernel testbench
// Streams file patterns through the kernel and checks every beat
//////////////////////////////
`timescale 1ns/100ps

module systolic_kernel_tb;
  import systolic_pkg::*;

  localparam int NUM_RECORDS    = 2;
  localparam int REC_LEN        = 1 + ARRAY_DIM + 2 * STREAM_BEATS;
  localparam int W_OFS          = 1;
  localparam int IN_OFS         = W_OFS + ARRAY_DIM;
  localparam int EXP_OFS        = IN_OFS + STREAM_BEATS;
  localparam int MAX_RUNS       = 2 * NUM_RECORDS;
  localparam int CYCLES_PER_RUN = 400;
  localparam int RESET_CYCLES   = 8;
  localparam int CLK_PERIOD     = 10;

  logic  ap_clk;
  logic  areset;
  logic  ap_start;
  logic  ap_idle;
  logic  ap_done;
  logic  ap_ready;
  logic  weights_loaded;
  logic  weight_tvalid;
  logic  weight_tready;
  beat_t weight_tdata;
  logic  input_tvalid;
  logic  input_tready;
  beat_t input_tdata;
  logic  output_tvalid;
  logic  output_tready;
  beat_t output_tdata;
  logic  output_tlast;

  // Records of control word, weights, inputs and expected outputs
  beat_t patterns [NUM_RECORDS * REC_LEN];
  int    seed;
  int    run_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  systolic_kernel systolic_kernel_i (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .ap_start       (ap_start),
    .ap_idle        (ap_idle),
    .ap_done        (ap_done),
    .ap_ready       (ap_ready),
    .weights_loaded (weights_loaded),
    .weight_tvalid  (weight_tvalid),
    .weight_tready  (weight_tready),
    .weight_tdata   (weight_tdata),
    .input_tvalid   (input_tvalid),
    .input_tready   (input_tready),
    .input_tdata    (input_tdata),
    .output_tvalid  (output_tvalid),
    .output_tready  (output_tready),
    .output_tdata   (output_tdata),
    .output_tlast   (output_tlast)
  );

  always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

  task automatic compare_value(input string name, input int index, input beat_t got,
                               input beat_t expected);
    assert (got === expected) else begin
      $display("Mismatch %s beat %0d: got %0h, expected %0h", name, index, got, expected);
      run_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      run_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    total_errors += run_errors;
    if (run_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, run_errors);
    end
  endtask

  // Output back-pressure, roughly one cycle in four stalled
  function automatic logic next_ready(input logic stalls);
    if (!stalls) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;
  endfunction

  //////////////////////////////
  // One kernel run from a pattern record
  //////////////////////////////
  task automatic run_record(input int rec, input logic stalls);
    int   base;
    int   w_sent;
    int   i_sent;
    int   o_seen;
    logic w_fire;
    logic i_fire;
    logic o_fire;
    logic idle_fell;
    logic finished;
    base       = rec * REC_LEN;
    w_sent     = 0;
    i_sent     = 0;
    o_seen     = 0;
    idle_fell  = 1'b0;
    finished   = 1'b0;
    run_errors = 0;
    @(posedge ap_clk);
    #1;
    ap_start      = 1'b1;
    weight_tvalid = 1'b1;
    weight_tdata  = patterns[base + W_OFS];
    input_tvalid  = 1'b1;
    input_tdata   = patterns[base + IN_OFS];
    output_tready = next_ready(stalls);
    while (!finished) begin
      // Handshakes sampled mid-cycle, they complete on the next rising edge
      @(negedge ap_clk);
      w_fire = weight_tvalid && weight_tready;
      i_fire = input_tvalid && input_tready;
      o_fire = output_tvalid && output_tready;
      if (!ap_idle) idle_fell = 1'b1;
      expect_true(ap_ready === ap_done, "ap_ready differs from ap_done");
      expect_true(!input_tready || weights_loaded, "input_tready high before weights loaded");
      if (w_sent == ARRAY_DIM) begin
        expect_true(weights_loaded, "weights_loaded low after four weight beats");
        expect_true(!weight_tready, "weight_tready still high after four weight beats");
      end else if (idle_fell) begin
        expect_true(!weights_loaded, "weights_loaded high before the fourth weight beat");
      end
      if (o_fire) begin
        if (o_seen < STREAM_BEATS) begin
          compare_value("output_tdata", o_seen, output_tdata,
                        patterns[base + EXP_OFS + o_seen]);
          compare_value("output_tlast", o_seen, beat_t'(output_tlast),
                        beat_t'(o_seen == STREAM_BEATS - 1));
        end else begin
          expect_true(1'b0, "output beat transferred after the last one");
        end
        o_seen++;
      end
      if (ap_done) begin
        expect_true(idle_fell, "ap_idle never fell after ap_start");
        expect_true(ap_idle, "ap_idle low while ap_done is high");
        expect_true(o_seen == STREAM_BEATS, "output beats lost before ap_done");
        expect_true(i_sent == STREAM_BEATS, "input beats left over at ap_done");
        @(negedge ap_clk);
        expect_true(!ap_done && !ap_ready, "ap_done or ap_ready longer than one cycle");
        expect_true(ap_idle, "ap_idle low after ap_done");
        finished = 1'b1;
      end else begin
        @(posedge ap_clk);
        #1;
        if (idle_fell) ap_start = 1'b0;
        if (w_fire) begin
          w_sent++;
          if (w_sent < ARRAY_DIM) begin
            weight_tdata = patterns[base + W_OFS + w_sent];
          end else begin
            weight_tvalid = 1'b0;
          end
        end
        if (i_fire) begin
          i_sent++;
          if (i_sent < STREAM_BEATS) begin
            input_tdata = patterns[base + IN_OFS + i_sent];
          end else begin
            input_tvalid = 1'b0;
          end
        end
        output_tready = next_ready(stalls);
      end
    end
    report_test($sformatf("record %0d, %s", rec, stalls ? "random stalls" : "no stalls"));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    ap_clk        = 1'b0;
    areset        = 1'b1;
    ap_start      = 1'b0;
    weight_tvalid = 1'b0;
    weight_tdata  = '0;
    input_tvalid  = 1'b0;
    input_tdata   = '0;
    output_tready = 1'b0;
    seed          = 5;
    total_errors  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    $readmemh("verification/systolic_patterns.mem", patterns);
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #1;
    areset = 1'b0;

    run_errors = 0;
    @(negedge ap_clk);
    expect_true(ap_idle && !ap_done && !ap_ready, "wrong idle/done/ready status after reset");
    expect_true(!weight_tready && !input_tready, "stream ready high after reset");
    expect_true(!output_tvalid && !weights_loaded, "output_tvalid or weights_loaded after reset");
    expect_true(!$isunknown(patterns[NUM_RECORDS * REC_LEN - 1]),
                "pattern file missing or too short");
    report_test("reset state");

    // Back to back runs, each record plain and then in its own stall mode
    for (int rec = 0; rec < NUM_RECORDS; rec++) begin
      run_record(rec, 1'b0);
      if (patterns[rec * REC_LEN] != '0) begin
        run_record(rec, 1'b1);
      end
    end

    $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((RESET_CYCLES + MAX_RUNS * CYCLES_PER_RUN) * CLK_PERIOD);
    $display("Timeout: kernel did not finish within %0d cycles",
             RESET_CYCLES + MAX_RUNS * CYCLES_PER_RUN);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- systolic_kernel.f
source/systolic_pkg.sv
source/mac_cell.sv
source/systolic_array.sv
source/kernel_control.sv
source/weight_loader.sv
source/stream_sequencer.sv
source/systolic_kernel.sv
verification/systolic_kernel_tb.sv

//--- verification/systolic_patterns.mem
// Per record: control word (1 = rerun with output stalls), 4 weight beats,
// 7 input beats, 7 expected output beats; lane 0 is the leftmost word
// Record 0: identity weights, outputs equal the skewed inputs
0
00000000000000000000000000000001
00000000000000000000000100000000
00000000000000010000000000000000
00000001000000000000000000000000
01020304000000000000000000000000
11121314050607080000000000000000
2122232415161718090A0B0C00000000
3132333425262728191A1B1C0D0E0F10
0000000035363738292A2B2C1D1E1F20
0000000000000000393A3B3C2D2E2F30
0000000000000000000000003D3E3F40
01020304000000000000000000000000
11121314050607080000000000000000
2122232415161718090A0B0C00000000
3132333425262728191A1B1C0D0E0F10
0000000035363738292A2B2C1D1E1F20
0000000000000000393A3B3C2D2E2F30
0000000000000000000000003D3E3F40
// Record 1: mixed-sign weights and inputs, products wrap modulo 2^32
1
0000000A00000006000000070000000B
000000010000000C00000004FFFFFFFD
0000000800000003FFFFFFFE0000000F
00000005FFFFFFFF0000000900000002
00000003000000000000000000000000
0000000B000000070000000000000000
00000006000000040000000200000000
0000000EFFFFFFF30000000900000005
00000000000000020000000800000001
00000000000000000000000C0000000A
00000000000000000000000040000000
0000007B000000000000000000000000
0000006A000000480000000000000000
00000022000000730000003800000000
800000620000006F00000086000000A0
0000000080000088000000B600000042
0000000000000000C00000AAFFFFFF9F
000000000000000000000000C0000016
